// ==== source/core_settings.svh ====
// core settings
// sizes and fixed constants of the execute subsystem
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define WORD_W    32
`define RF_ADDR_W 5
// also the issuer's credit count after reset
`define IQ_DEPTH  4
`define MEM_WORDS 64
// word index width of the data memory
`define MEM_AW    $clog2(`MEM_WORDS)
`define MEM_LAT   2
`define RESET_PC  32'h0000_0100

`endif

// ==== source/core_pkg.sv ====
// core package
// opcode encoding and the two instruction formats of the execute subsystem
`include "core_settings.svh"

package core_pkg;

   typedef enum logic [5:0] {
      OP_ADD  = 6'h01,
      OP_SUB  = 6'h02,
      OP_AND  = 6'h03,
      OP_OR   = 6'h04,
      OP_XOR  = 6'h05,
      OP_ADDI = 6'h10,
      OP_LW   = 6'h20,
      OP_SW   = 6'h21
   } op_e;

   // register format for the two-source alu ops
   typedef struct packed {
      op_e                   opcode;
      logic [`RF_ADDR_W-1:0] rd;
      logic [`RF_ADDR_W-1:0] ra;
      logic [`RF_ADDR_W-1:0] rb;
      logic [10:0]           pad;
   } r_fmt_t;

   // immediate format for addi, lw and sw
   // sw stores register rd to address ra + imm
   typedef struct packed {
      op_e                   opcode;
      logic [`RF_ADDR_W-1:0] rd;
      logic [`RF_ADDR_W-1:0] ra;
      logic signed [15:0]    imm;
   } i_fmt_t;

   // one word, read as either format depending on opcode
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

endpackage

// ==== source/stage_if.sv ====
// execute to control stage bundle
// execute results on one side, registered control stage copies on the other
`include "core_settings.svh"

interface stage_if ();
   import core_pkg::*;

   // execute side
   logic                  valid;
   op_e                   op;
   logic [`RF_ADDR_W-1:0] rd;
   logic                  rf_wb;
   logic [`WORD_W-1:0]    alu_result;
   logic [`WORD_W-1:0]    lsu_adr;
   logic [`WORD_W-1:0]    store_data;
   logic [`WORD_W-1:0]    pc;
   logic                  misalign;

   // control stage copies
   logic                  c_valid;
   op_e                   c_op;
   logic [`RF_ADDR_W-1:0] c_rd;
   logic                  c_rf_wb;
   logic                  c_kill;
   logic [`WORD_W-1:0]    c_alu_result;
   logic [`WORD_W-1:0]    c_lsu_adr;
   logic [`WORD_W-1:0]    c_store_data;
   logic [`WORD_W-1:0]    c_pc;

   modport exe (output valid, op, rd, rf_wb, alu_result, lsu_adr, store_data, pc, misalign);
   modport stage (input valid, op, rd, rf_wb, alu_result, lsu_adr, store_data, pc, misalign);
   modport ctrl (output c_valid, c_op, c_rd, c_rf_wb, c_kill, c_alu_result, c_lsu_adr,
                 c_store_data, c_pc);

endinterface

// ==== source/issue_queue.sv ====
// issue queue
// fifo between the external issuer and execute, tags each word with its pc
// and returns one credit for every entry handed to execute
`include "core_settings.svh"

module issue_queue (
   input  logic               clk,
   input  logic               rst,
   input  logic               issue_valid_i,
   input  core_pkg::instr_u   issue_instr_i,
   input  logic               pop_i,
   output logic               head_valid_o,
   output core_pkg::instr_u   head_instr_o,
   output logic [`WORD_W-1:0] head_pc_o,
   output logic               credit_o
);
   import core_pkg::*;

   localparam int PTR_W = $clog2(`IQ_DEPTH);

   instr_u             instr_q [`IQ_DEPTH];
   logic [`WORD_W-1:0] pc_q    [`IQ_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [PTR_W:0]     count;
   logic [`WORD_W-1:0] next_pc;

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         next_pc  <= `RESET_PC;
         credit_o <= 1'b0;
      end else begin
         credit_o <= pop_i;
         if (issue_valid_i) begin
            wr_ptr  <= wr_ptr + 1'b1;
            next_pc <= next_pc + `WORD_W'(4);
         end
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
         case ({issue_valid_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // no overflow check, the issuer only sends with a credit in hand
   always_ff @(posedge clk) begin
      if (issue_valid_i) begin
         instr_q[wr_ptr] <= issue_instr_i;
         pc_q[wr_ptr]    <= next_pc;
      end
   end

   assign head_valid_o = (count != '0);
   assign head_instr_o = instr_q[rd_ptr];
   assign head_pc_o    = pc_q[rd_ptr];

endmodule

// ==== source/reg_file.sv ====
// register file
// two asynchronous read ports and one synchronous write port,
// register 0 is hardwired to zero
`include "core_settings.svh"

module reg_file (
   input  logic                  clk,
   input  logic [`RF_ADDR_W-1:0] ra_i,
   input  logic [`RF_ADDR_W-1:0] rb_i,
   output logic [`WORD_W-1:0]    ra_data_o,
   output logic [`WORD_W-1:0]    rb_data_o,
   input  logic                  we_i,
   input  logic [`RF_ADDR_W-1:0] wa_i,
   input  logic [`WORD_W-1:0]    wd_i
);

   logic [`WORD_W-1:0] regs [2**`RF_ADDR_W];

   always_ff @(posedge clk) begin
      if (we_i && (wa_i != '0))
         regs[wa_i] <= wd_i;
   end

   assign ra_data_o = (ra_i == '0) ? '0 : regs[ra_i];
   assign rb_data_o = (rb_i == '0) ? '0 : regs[rb_i];

endmodule

// ==== source/execute_unit.sv ====
// execute unit
// decodes the queue head, reads and bypasses operands, computes the alu
// result and the load/store address, and holds on a load-use hazard
`include "core_settings.svh"

module execute_unit (
   input  logic                  clk,
   input  logic                  head_valid_i,
   input  core_pkg::instr_u      head_instr_i,
   input  logic [`WORD_W-1:0]    head_pc_i,
   output logic                  pop_o,
   output logic                  advance_o,
   input  logic                  ctrl_valid_i,
   input  core_pkg::op_e         ctrl_op_i,
   input  logic                  ctrl_we_i,
   input  logic [`RF_ADDR_W-1:0] ctrl_rd_i,
   input  logic [`WORD_W-1:0]    ctrl_result_i,
   input  logic                  wb_we_i,
   input  logic [`RF_ADDR_W-1:0] wb_rd_i,
   input  logic [`WORD_W-1:0]    wb_data_i,
   stage_if.exe                  stage_o
);
   import core_pkg::*;

   op_e                   op;
   logic [`RF_ADDR_W-1:0] ra_idx;
   logic [`RF_ADDR_W-1:0] rb_idx;
   logic [`WORD_W-1:0]    ra_rf;
   logic [`WORD_W-1:0]    rb_rf;
   logic [`WORD_W-1:0]    op_a;
   logic [`WORD_W-1:0]    op_b;
   logic [`WORD_W-1:0]    imm_ext;
   logic [`WORD_W-1:0]    alu;
   logic [`WORD_W-1:0]    adr;
   logic                  use_rb;
   logic                  is_mem;
   logic                  load_in_ctrl;
   logic                  stall;

   assign op      = head_instr_i.r.opcode;
   assign ra_idx  = head_instr_i.r.ra;
   // stores read their data register through the second port
   assign rb_idx  = (op == OP_SW) ? head_instr_i.i.rd : head_instr_i.r.rb;
   assign imm_ext = {{(`WORD_W-16){head_instr_i.i.imm[15]}}, head_instr_i.i.imm};
   assign use_rb  = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SW};
   assign is_mem  = (op == OP_LW) || (op == OP_SW);

   reg_file u_rf (
      .clk       (clk),
      .ra_i      (ra_idx),
      .rb_i      (rb_idx),
      .ra_data_o (ra_rf),
      .rb_data_o (rb_rf),
      .we_i      (wb_we_i),
      .wa_i      (wb_rd_i),
      .wd_i      (wb_data_i)
   );

   // control stage wins over writeback, the younger result is the right one
   function automatic logic [`WORD_W-1:0] fwd(input logic [`RF_ADDR_W-1:0] idx,
                                              input logic [`WORD_W-1:0]    rf_val);
      if ((idx != '0) && ctrl_we_i && (ctrl_rd_i == idx))
         return ctrl_result_i;
      if ((idx != '0) && wb_we_i && (wb_rd_i == idx))
         return wb_data_i;
      return rf_val;
   endfunction

   always_comb begin
      op_a = fwd(ra_idx, ra_rf);
      op_b = fwd(rb_idx, rb_rf);
   end

   // load data is not there before writeback
   assign load_in_ctrl = ctrl_we_i && (ctrl_op_i == OP_LW) && (ctrl_rd_i != '0);
   assign stall = head_valid_i && load_in_ctrl &&
                  ((ctrl_rd_i == ra_idx) || (use_rb && (ctrl_rd_i == rb_idx)));

   assign advance_o = ctrl_valid_i && !stall;
   assign pop_o     = advance_o && head_valid_i;

   always_comb begin
      case (op)
         OP_SUB:  alu = op_a - op_b;
         OP_AND:  alu = op_a & op_b;
         OP_OR:   alu = op_a | op_b;
         OP_XOR:  alu = op_a ^ op_b;
         OP_ADDI: alu = op_a + imm_ext;
         default: alu = op_a + op_b;
      endcase
   end

   assign adr = op_a + imm_ext;

   assign stage_o.valid      = head_valid_i;
   assign stage_o.op         = op;
   assign stage_o.rd         = head_instr_i.r.rd;
   assign stage_o.rf_wb      = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                          OP_ADDI, OP_LW};
   assign stage_o.alu_result = alu;
   assign stage_o.lsu_adr    = adr;
   assign stage_o.store_data = op_b;
   assign stage_o.pc         = head_pc_i;
   assign stage_o.misalign   = is_mem && (adr[1:0] != 2'b00);

endmodule

// ==== source/exec_ctrl_stage.sv ====
// execute to control stage register
// holds loads and stores until the lsu is done, kills misaligned accesses
// with an exception report, and feeds the writeback register
`include "core_settings.svh"

module exec_ctrl_stage (
   input  logic                  clk,
   input  logic                  rst,
   stage_if.stage                stage_i,
   stage_if.ctrl                 ctrl_o,
   input  logic                  advance_i,
   input  logic                  lsu_valid_i,
   input  logic [`WORD_W-1:0]    lsu_rdata_i,
   output logic                  lsu_req_o,
   output logic                  ctrl_valid_o,
   output logic                  wb_we_o,
   output logic [`RF_ADDR_W-1:0] wb_rd_o,
   output logic [`WORD_W-1:0]    wb_data_o,
   output logic                  except_valid_o,
   output logic [`WORD_W-1:0]    except_pc_o
);
   import core_pkg::*;

   logic exe_mem;
   logic ctrl_mem;
   logic ctrl_load;

   assign exe_mem   = (stage_i.op == OP_LW) || (stage_i.op == OP_SW);
   assign ctrl_load = (ctrl_o.c_op == OP_LW);
   assign ctrl_mem  = ctrl_load || (ctrl_o.c_op == OP_SW);

   // a live load or store stays here until the lsu reports completion
   assign ctrl_valid_o = !(ctrl_o.c_valid && !ctrl_o.c_kill && ctrl_mem && !lsu_valid_i);

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_o.c_valid <= 1'b0;
         ctrl_o.c_kill  <= 1'b0;
         ctrl_o.c_rf_wb <= 1'b0;
         lsu_req_o      <= 1'b0;
      end else begin
         // one request per access, none for a killed one
         lsu_req_o <= advance_i && stage_i.valid && exe_mem && !stage_i.misalign;
         if (advance_i) begin
            ctrl_o.c_valid <= stage_i.valid;
            ctrl_o.c_kill  <= stage_i.valid && stage_i.misalign;
            ctrl_o.c_rf_wb <= stage_i.valid && stage_i.rf_wb && !stage_i.misalign;
         end else if (ctrl_valid_o) begin
            // execute is held on load-use, a bubble takes the slot
            // the write enable drops here too so no stale bypass remains
            ctrl_o.c_valid <= 1'b0;
            ctrl_o.c_kill  <= 1'b0;
            ctrl_o.c_rf_wb <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (advance_i) begin
         ctrl_o.c_op         <= stage_i.op;
         ctrl_o.c_rd         <= stage_i.rd;
         ctrl_o.c_alu_result <= stage_i.alu_result;
         ctrl_o.c_lsu_adr    <= stage_i.lsu_adr;
         ctrl_o.c_store_data <= stage_i.store_data;
         ctrl_o.c_pc         <= stage_i.pc;
      end
   end

   // writeback register
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_we_o        <= 1'b0;
         except_valid_o <= 1'b0;
      end else begin
         // a load only moves on in the cycle its data arrives
         wb_we_o        <= ctrl_o.c_rf_wb && ctrl_valid_o;
         except_valid_o <= ctrl_o.c_valid && ctrl_o.c_kill;
      end
   end

   always_ff @(posedge clk) begin
      wb_rd_o     <= ctrl_o.c_rd;
      wb_data_o   <= ctrl_load ? lsu_rdata_i : ctrl_o.c_alu_result;
      except_pc_o <= ctrl_o.c_pc;
   end

endmodule

// ==== source/lsu.sv ====
// load/store unit
// turns a control stage request into one data memory command and
// signals completion, with the load data when there is any
`include "core_settings.svh"

module lsu (
   input  logic               clk,
   input  logic               rst,
   input  logic               req_i,
   input  core_pkg::op_e      op_i,
   input  logic [`WORD_W-1:0] adr_i,
   input  logic [`WORD_W-1:0] wdata_i,
   output logic               valid_o,
   output logic [`WORD_W-1:0] rdata_o,
   output logic               mem_we_o,
   output logic               mem_re_o,
   output logic [`MEM_AW-1:0] mem_adr_o,
   output logic [`WORD_W-1:0] mem_wdata_o,
   input  logic [`WORD_W-1:0] mem_rdata_i,
   input  logic               mem_rvalid_i
);
   import core_pkg::*;

   logic load_pend;
   logic store_done;

   assign mem_re_o    = req_i && (op_i == OP_LW);
   assign mem_we_o    = req_i && (op_i == OP_SW);
   // word index, misaligned accesses never get here
   assign mem_adr_o   = adr_i[`MEM_AW+1:2];
   assign mem_wdata_o = wdata_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         load_pend  <= 1'b0;
         store_done <= 1'b0;
      end else begin
         store_done <= mem_we_o;
         if (mem_re_o)
            load_pend <= 1'b1;
         else if (mem_rvalid_i)
            load_pend <= 1'b0;
      end
   end

   assign valid_o = store_done || (load_pend && mem_rvalid_i);
   assign rdata_o = mem_rdata_i;

endmodule

// ==== source/data_mem.sv ====
// data memory
// word array cleared at reset, reads return after MEM_LAT cycles
`include "core_settings.svh"

module data_mem (
   input  logic               clk,
   input  logic               rst,
   input  logic               we_i,
   input  logic               re_i,
   input  logic [`MEM_AW-1:0] adr_i,
   input  logic [`WORD_W-1:0] wdata_i,
   output logic [`WORD_W-1:0] rdata_o,
   output logic               rvalid_o
);

   logic [`WORD_W-1:0]  mem     [`MEM_WORDS];
   logic [`WORD_W-1:0]  rd_pipe [`MEM_LAT];
   logic [`MEM_LAT-1:0] rv_pipe;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `MEM_WORDS; i++)
            mem[i] <= '0;
      end else if (we_i) begin
         mem[adr_i] <= wdata_i;
      end
   end

   // read valid moves along with its data
   always_ff @(posedge clk) begin
      if (rst) begin
         rv_pipe <= '0;
      end else begin
         rv_pipe[0] <= re_i;
         for (int s = 1; s < `MEM_LAT; s++)
            rv_pipe[s] <= rv_pipe[s-1];
      end
   end

   always_ff @(posedge clk) begin
      rd_pipe[0] <= mem[adr_i];
      for (int s = 1; s < `MEM_LAT; s++)
         rd_pipe[s] <= rd_pipe[s-1];
   end

   assign rvalid_o = rv_pipe[`MEM_LAT-1];
   assign rdata_o  = rd_pipe[`MEM_LAT-1];

endmodule

// ==== source/exec_subsys_top.sv ====
// execute subsystem top
// issue queue, execute, control stage, lsu and data memory
`include "core_settings.svh"

module exec_subsys_top (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  issue_valid_i,
   input  logic [`WORD_W-1:0]    issue_instr_i,
   output logic                  credit_o,
   output logic                  retire_valid_o,
   output logic [`RF_ADDR_W-1:0] retire_rd_o,
   output logic [`WORD_W-1:0]    retire_data_o,
   output logic                  except_valid_o,
   output logic [`WORD_W-1:0]    except_pc_o
);
   import core_pkg::*;

   logic               iq_valid;
   instr_u             iq_instr;
   logic [`WORD_W-1:0] iq_pc;
   logic               iq_pop;
   logic               advance;
   logic               ctrl_valid;
   logic               lsu_req;
   logic               lsu_valid;
   logic [`WORD_W-1:0] lsu_rdata;
   logic               mem_we;
   logic               mem_re;
   logic [`MEM_AW-1:0] mem_adr;
   logic [`WORD_W-1:0] mem_wdata;
   logic [`WORD_W-1:0] mem_rdata;
   logic               mem_rvalid;

   stage_if st ();

   issue_queue u_iq (
      .clk           (clk),
      .rst           (rst),
      .issue_valid_i (issue_valid_i),
      .issue_instr_i (issue_instr_i),
      .pop_i         (iq_pop),
      .head_valid_o  (iq_valid),
      .head_instr_o  (iq_instr),
      .head_pc_o     (iq_pc),
      .credit_o      (credit_o)
   );

   // writeback results double as the retire report
   execute_unit u_exe (
      .clk           (clk),
      .head_valid_i  (iq_valid),
      .head_instr_i  (iq_instr),
      .head_pc_i     (iq_pc),
      .pop_o         (iq_pop),
      .advance_o     (advance),
      .ctrl_valid_i  (ctrl_valid),
      .ctrl_op_i     (st.c_op),
      .ctrl_we_i     (st.c_rf_wb),
      .ctrl_rd_i     (st.c_rd),
      .ctrl_result_i (st.c_alu_result),
      .wb_we_i       (retire_valid_o),
      .wb_rd_i       (retire_rd_o),
      .wb_data_i     (retire_data_o),
      .stage_o       (st.exe)
   );

   exec_ctrl_stage u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .stage_i        (st.stage),
      .ctrl_o         (st.ctrl),
      .advance_i      (advance),
      .lsu_valid_i    (lsu_valid),
      .lsu_rdata_i    (lsu_rdata),
      .lsu_req_o      (lsu_req),
      .ctrl_valid_o   (ctrl_valid),
      .wb_we_o        (retire_valid_o),
      .wb_rd_o        (retire_rd_o),
      .wb_data_o      (retire_data_o),
      .except_valid_o (except_valid_o),
      .except_pc_o    (except_pc_o)
   );

   lsu u_lsu (
      .clk          (clk),
      .rst          (rst),
      .req_i        (lsu_req),
      .op_i         (st.c_op),
      .adr_i        (st.c_lsu_adr),
      .wdata_i      (st.c_store_data),
      .valid_o      (lsu_valid),
      .rdata_o      (lsu_rdata),
      .mem_we_o     (mem_we),
      .mem_re_o     (mem_re),
      .mem_adr_o    (mem_adr),
      .mem_wdata_o  (mem_wdata),
      .mem_rdata_i  (mem_rdata),
      .mem_rvalid_i (mem_rvalid)
   );

   data_mem u_mem (
      .clk      (clk),
      .rst      (rst),
      .we_i     (mem_we),
      .re_i     (mem_re),
      .adr_i    (mem_adr),
      .wdata_i  (mem_wdata),
      .rdata_o  (mem_rdata),
      .rvalid_o (mem_rvalid)
   );

endmodule

// ==== sim/exec_subsys_asserts.sv ====
// control stage checks
// lsu requests, load writeback and exception pulses of the stage register
`include "core_settings.svh"

module exec_subsys_asserts (
   input logic               clk,
   input logic               rst,
   input logic               lsu_req_i,
   input logic [1:0]         adr_low_i,
   input logic               load_i,
   input logic               ctrl_we_i,
   input logic               lsu_valid_i,
   input logic               wb_we_i,
   input logic               except_valid_i,
   input logic [`WORD_W-1:0] except_pc_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // a misaligned access never reaches the lsu
   req_not_killed: assert property (@(posedge clk) disable iff (rst)
      lsu_req_i |-> (adr_low_i == 2'b00))
      else $error("lsu request raised for a killed access");

   // a load still waiting on memory gives no writeback
   load_wb_after_data: assert property (@(posedge clk) disable iff (rst)
      (load_i && ctrl_we_i && !lsu_valid_i) |=> !wb_we_i)
      else $error("writeback enable raised before the load data arrived");

   // each killed access reports once, a report right after it is for a younger access
   except_single_pulse: assert property (@(posedge clk) disable iff (rst)
      except_valid_i |=> (!except_valid_i || (except_pc_i != $past(except_pc_i))))
      else $error("exception report lasted more than one cycle");

endmodule

bind exec_ctrl_stage exec_subsys_asserts u_asserts (
   .clk            (clk),
   .rst            (rst),
   .lsu_req_i      (lsu_req_o),
   .adr_low_i      (ctrl_o.c_lsu_adr[1:0]),
   .load_i         (ctrl_load),
   .ctrl_we_i      (ctrl_o.c_rf_wb),
   .lsu_valid_i    (lsu_valid_i),
   .wb_we_i        (wb_we_o),
   .except_valid_i (except_valid_o),
   .except_pc_i    (except_pc_o)
);

// ==== sim/tb_exec_subsys.sv ====
// testbench for the execute subsystem
// a directed prologue and a random program, issued under credit flow control
// and checked against a reference model of registers and memory
`include "core_settings.svh"

module tb_exec_subsys;
   timeunit 1ns;
   timeprecision 100ps;
   import core_pkg::*;

   localparam int N_DIRECTED = 11;
   localparam int N_RANDOM   = 300;
   localparam int N_TOTAL    = N_DIRECTED + N_RANDOM;

   logic                  clk;
   logic                  rst;
   logic                  issue_valid_i;
   logic [`WORD_W-1:0]    issue_instr_i;
   logic                  credit_o;
   logic                  retire_valid_o;
   logic [`RF_ADDR_W-1:0] retire_rd_o;
   logic [`WORD_W-1:0]    retire_data_o;
   logic                  except_valid_o;
   logic [`WORD_W-1:0]    except_pc_o;

   integer                seed     = 32'hd19008a0;
   int                    sent     = 0;
   int                    returned = 0;
   logic [`WORD_W-1:0]    model_rf  [2**`RF_ADDR_W];
   logic [`WORD_W-1:0]    model_mem [`MEM_WORDS];
   logic [`RF_ADDR_W-1:0] exp_rd_q   [$];
   logic [`WORD_W-1:0]    exp_data_q [$];
   logic [`WORD_W-1:0]    exp_pc_q   [$];

   exec_subsys_top dut (
      .clk            (clk),
      .rst            (rst),
      .issue_valid_i  (issue_valid_i),
      .issue_instr_i  (issue_instr_i),
      .credit_o       (credit_o),
      .retire_valid_o (retire_valid_o),
      .retire_rd_o    (retire_rd_o),
      .retire_data_o  (retire_data_o),
      .except_valid_o (except_valid_o),
      .except_pc_o    (except_pc_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "run stopped at the first error");
   endtask

   function automatic instr_u r_word(input op_e op, input logic [`RF_ADDR_W-1:0] rd,
                                     input logic [`RF_ADDR_W-1:0] ra,
                                     input logic [`RF_ADDR_W-1:0] rb);
      instr_u w;
      w.r.opcode = op;
      w.r.rd     = rd;
      w.r.ra     = ra;
      w.r.rb     = rb;
      w.r.pad    = '0;
      return w;
   endfunction

   function automatic instr_u i_word(input op_e op, input logic [`RF_ADDR_W-1:0] rd,
                                     input logic [`RF_ADDR_W-1:0] ra,
                                     input logic [15:0] imm);
      instr_u w;
      w.i.opcode = op;
      w.i.rd     = rd;
      w.i.ra     = ra;
      w.i.imm    = imm;
      return w;
   endfunction

   // writes r1..r7 before the random part reads them
   function automatic instr_u directed_instr(input int k);
      case (k)
         0:       return i_word(OP_ADDI, 5'd1, 5'd0, 16'h1234);
         1:       return i_word(OP_ADDI, 5'd2, 5'd1, 16'hfffb);
         // r1 from writeback, r2 from control
         2:       return r_word(OP_ADD, 5'd3, 5'd1, 5'd2);
         3:       return i_word(OP_ADDI, 5'd0, 5'd0, 16'h0007);
         4:       return r_word(OP_ADD, 5'd4, 5'd0, 5'd1);
         5:       return i_word(OP_SW, 5'd3, 5'd0, 16'h0008);
         6:       return i_word(OP_LW, 5'd5, 5'd0, 16'h0008);
         // load-use on r5
         7:       return r_word(OP_ADD, 5'd6, 5'd5, 5'd5);
         8:       return i_word(OP_LW, 5'd7, 5'd0, 16'h0006);
         9:       return i_word(OP_SW, 5'd3, 5'd0, 16'h0001);
         default: return r_word(OP_XOR, 5'd7, 5'd6, 5'd1);
      endcase
   endfunction

   // small register set so that dependencies are frequent
   function automatic instr_u random_instr();
      int unsigned           pick;
      logic [`RF_ADDR_W-1:0] rd;
      logic [`RF_ADDR_W-1:0] ra;
      logic [`RF_ADDR_W-1:0] rb;
      logic [15:0]           imm;
      logic [15:0]           off;
      logic [15:0]           bad;
      pick = $unsigned($random(seed)) % 16;
      rd   = `RF_ADDR_W'($unsigned($random(seed)) % 8);
      ra   = `RF_ADDR_W'($unsigned($random(seed)) % 8);
      rb   = `RF_ADDR_W'($unsigned($random(seed)) % 8);
      imm  = 16'($random(seed));
      off  = 16'(($unsigned($random(seed)) % 16) * 4);
      bad  = off + 16'(1 + $unsigned($random(seed)) % 3);
      case (pick)
         0, 1:      return r_word(OP_ADD, rd, ra, rb);
         2:         return r_word(OP_SUB, rd, ra, rb);
         3:         return r_word(OP_AND, rd, ra, rb);
         4:         return r_word(OP_OR, rd, ra, rb);
         5:         return r_word(OP_XOR, rd, ra, rb);
         6, 7, 8:   return i_word(OP_ADDI, rd, ra, imm);
         9, 10, 11: return i_word(OP_LW, rd, 5'd0, off);
         12, 13:    return i_word(OP_SW, rd, 5'd0, off);
         14:        return i_word(OP_LW, rd, 5'd0, bad);
         default:   return i_word(OP_SW, rd, 5'd0, bad);
      endcase
   endfunction

   function automatic void expect_retire(input logic [`RF_ADDR_W-1:0] rd,
                                         input logic [`WORD_W-1:0] data);
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(data);
      if (rd != '0)
         model_rf[rd] = data;
   endfunction

   // reference model, one instruction at a time in issue order
   function automatic void ref_exec(input instr_u ins, input logic [`WORD_W-1:0] pc);
      logic [`WORD_W-1:0] a;
      logic [`WORD_W-1:0] b;
      logic [`WORD_W-1:0] imm;
      logic [`WORD_W-1:0] adr;
      int                 idx;
      a   = model_rf[ins.r.ra];
      b   = model_rf[ins.r.rb];
      imm = {{(`WORD_W-16){ins.i.imm[15]}}, ins.i.imm};
      adr = a + imm;
      idx = int'((adr >> 2) % `MEM_WORDS);
      case (ins.r.opcode)
         OP_ADD:  expect_retire(ins.r.rd, a + b);
         OP_SUB:  expect_retire(ins.r.rd, a - b);
         OP_AND:  expect_retire(ins.r.rd, a & b);
         OP_OR:   expect_retire(ins.r.rd, a | b);
         OP_XOR:  expect_retire(ins.r.rd, a ^ b);
         OP_ADDI: expect_retire(ins.i.rd, a + imm);
         OP_LW: begin
            if (adr[1:0] != 2'b00)
               exp_pc_q.push_back(pc);
            else
               expect_retire(ins.i.rd, model_mem[idx]);
         end
         OP_SW: begin
            if (adr[1:0] != 2'b00)
               exp_pc_q.push_back(pc);
            else
               model_mem[idx] = model_rf[ins.i.rd];
         end
         default: ;
      endcase
   endfunction

   task automatic check_retire(input logic [`RF_ADDR_W-1:0] rd,
                               input logic [`WORD_W-1:0] data);
      logic [`RF_ADDR_W-1:0] rd_exp;
      logic [`WORD_W-1:0]    data_exp;
      if (exp_rd_q.size() == 0) begin
         report_failure("a result retired while none was expected");
      end else begin
         rd_exp   = exp_rd_q.pop_front();
         data_exp = exp_data_q.pop_front();
         if (rd !== rd_exp)
            report_failure($sformatf("MISMATCH retire_rd_o expected %h got %h", rd_exp, rd));
         else if (data !== data_exp)
            report_failure($sformatf("MISMATCH retire_data_o expected %h got %h",
                                     data_exp, data));
      end
   endtask

   task automatic check_except(input logic [`WORD_W-1:0] pc);
      logic [`WORD_W-1:0] pc_exp;
      if (exp_pc_q.size() == 0) begin
         report_failure("an exception was reported while none was expected");
      end else begin
         pc_exp = exp_pc_q.pop_front();
         if (pc !== pc_exp)
            report_failure($sformatf("MISMATCH except_pc_o expected %h got %h", pc_exp, pc));
      end
   endtask

   // outputs are registered, sample them away from the rising edge
   always @(negedge clk) begin
      if (!rst) begin
         if (retire_valid_o)
            check_retire(retire_rd_o, retire_data_o);
         else if (except_valid_o)
            check_except(except_pc_o);
      end
   end

   // credit mirror, each pulse gives one word back to the issuer
   always @(negedge clk) begin
      if (!rst && credit_o) begin
         if (returned >= sent)
            report_failure("a credit came back with no word outstanding");
         else
            returned++;
      end
   end

   initial begin
      instr_u w;
      rst           = 1'b1;
      issue_valid_i = 1'b0;
      issue_instr_i = '0;
      for (int r = 0; r < 2**`RF_ADDR_W; r++)
         model_rf[r] = '0;
      for (int m = 0; m < `MEM_WORDS; m++)
         model_mem[m] = '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      for (int n = 0; n < N_TOTAL; n++) begin
         // no credit in hand, no word on the bus
         while (sent - returned >= `IQ_DEPTH) begin
            issue_valid_i <= 1'b0;
            @(posedge clk);
         end
         w = (n < N_DIRECTED) ? directed_instr(n) : random_instr();
         issue_valid_i <= 1'b1;
         issue_instr_i <= w;
         ref_exec(w, `RESET_PC + `WORD_W'(4 * n));
         sent++;
         @(posedge clk);
         if (($unsigned($random(seed)) % 5) == 0) begin
            issue_valid_i <= 1'b0;
            @(posedge clk);
         end
      end
      issue_valid_i <= 1'b0;
      while (returned != sent)
         @(posedge clk);
      // every word has left the queue, a load needs at most MEM_LAT+2 more cycles
      // to retire, the rest catches any extra report
      repeat (8) @(posedge clk);
      if (exp_rd_q.size() == 0 && exp_pc_q.size() == 0 && returned == sent) begin
         $display("all tests passed");
         $finish;
      end else begin
         report_failure("results or credits were left over at the end of the run");
      end
   end

   // twenty cycles per issued word
   initial begin
      repeat (N_TOTAL * 20 + 4) @(posedge clk);
      report_failure("timeout, the program did not complete in time");
   end

endmodule

// ==== sim.f ====
+incdir+source
source/core_pkg.sv
source/stage_if.sv
source/issue_queue.sv
source/reg_file.sv
source/execute_unit.sv
source/exec_ctrl_stage.sv
source/lsu.sv
source/data_mem.sv
source/exec_subsys_top.sv
sim/exec_subsys_asserts.sv
sim/tb_exec_subsys.sv

// ==== Makefile ====
SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP       = tb_exec_subsys
FILELIST  = sim.f
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
